//--- src/mem_macros.svh
// memory path parameters
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// request queue entries
`define FIFO_DEPTH 4
// free slots at or below which rqfull rises
`define FIFO_AFULL_MARGIN 2

// 128-bit lines in the store
`define LINE_ENTRIES 16
// pop to write finish
`define DRAM_WR_CYCLES 4
// pop to read data valid
`define DRAM_RD_CYCLES 6

`endif

//--- src/dram_types_pkg.sv
// line store types
package dram_types_pkg;

	typedef logic [127:0] line_data_t; // one dram line
	typedef logic [15:0] byte_mask_t; // 1 keeps the byte, as on mig
	typedef logic [3:0] line_idx_t; // address bits 7:4

	// controller fsm
	typedef enum logic [1:0] {
		CTRL_IDLE,
		CTRL_WRITE,
		CTRL_READ,
		CTRL_RESP
	} ctrl_state_e;

endpackage

//--- src/bus_types_pkg.sv
// requester side bus types
package bus_types_pkg;
	import dram_types_pkg::*;

	typedef logic [31:0] bus_addr_t; // low 4 bits ignored

	typedef enum logic {
		SRC_UART,
		SRC_DC
	} req_src_e;

	typedef enum logic {
		CMD_WRITE,
		CMD_READ
	} req_cmd_e;

	// one queue entry
	typedef struct packed {
		req_src_e src;
		req_cmd_e cmd;
		bus_addr_t addr;
		line_data_t data;
		byte_mask_t mask;
	} line_req_t;

	// response toward one requester
	typedef struct packed {
		logic finish_wresp; // write done strobe
		logic rdat_valid; // read data strobe
		line_data_t rdat;
	} line_rsp_t;

endpackage

//--- src/bus_req_arbiter.sv
// request arbiter
`timescale 1ns/1ns

module bus_req_arbiter
	import bus_types_pkg::*;
	import dram_types_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input logic i_uart_wstart_rq,
	input bus_addr_t i_uart_win_addr,
	input line_data_t i_uart_in_wdata,
	input byte_mask_t i_uart_in_mask,
	input logic i_uart_rstart_rq,
	input bus_addr_t i_uart_rin_addr,
	input logic i_dc_wstart_rq,
	input bus_addr_t i_dc_win_addr,
	input line_data_t i_dc_in_wdata,
	input byte_mask_t i_dc_in_mask,
	input logic i_dc_rstart_rq,
	input bus_addr_t i_dc_rin_addr,
	output logic o_push,
	output line_req_t o_req
);

	logic [1:0] new_vld; // indexed by req_src_e
	line_req_t new_req [2];
	logic [1:0] pend_vld;
	line_req_t pend_req [2];
	logic [1:0] take_pend;
	logic [1:0] take_new;
	line_req_t sel_req;

	function automatic line_req_t make_req(
		input req_src_e src,
		input logic wstart,
		input bus_addr_t waddr,
		input line_data_t wdata,
		input byte_mask_t mask,
		input bus_addr_t raddr
	);
		line_req_t req;
		req.src = src;
		req.cmd = wstart ? CMD_WRITE : CMD_READ;
		req.addr = wstart ? waddr : raddr;
		req.data = wdata;
		req.mask = mask;
		return req;
	endfunction

	always_comb begin
		new_vld[SRC_UART] = i_uart_wstart_rq | i_uart_rstart_rq;
		new_vld[SRC_DC] = i_dc_wstart_rq | i_dc_rstart_rq;
		new_req[SRC_UART] = make_req(SRC_UART, i_uart_wstart_rq, i_uart_win_addr,
			i_uart_in_wdata, i_uart_in_mask, i_uart_rin_addr);
		new_req[SRC_DC] = make_req(SRC_DC, i_dc_wstart_rq, i_dc_win_addr,
			i_dc_in_wdata, i_dc_in_mask, i_dc_rin_addr);
	end

	// pending first, then dc before uart
	always_comb begin
		take_pend = '0;
		take_new = '0;
		sel_req = pend_req[SRC_DC];
		if (pend_vld[SRC_DC]) begin
			take_pend[SRC_DC] = 1'b1;
		end else if (pend_vld[SRC_UART]) begin
			take_pend[SRC_UART] = 1'b1;
			sel_req = pend_req[SRC_UART];
		end else if (new_vld[SRC_DC]) begin
			take_new[SRC_DC] = 1'b1;
			sel_req = new_req[SRC_DC];
		end else if (new_vld[SRC_UART]) begin
			take_new[SRC_UART] = 1'b1;
			sel_req = new_req[SRC_UART];
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_push <= 1'b0;
			pend_vld <= '0;
		end else begin
			o_push <= |{take_pend, take_new};
			for (int s = 0; s < 2; s++) begin
				pend_vld[s] <= (pend_vld[s] & ~take_pend[s]) | (new_vld[s] & ~take_new[s]);
			end
		end
	end

	always_ff @(posedge i_clk) begin
		o_req <= sel_req;
		for (int s = 0; s < 2; s++) begin
			if (new_vld[s] & ~take_new[s])
				pend_req[s] <= new_req[s]; // loser parks here
		end
	end

	// a requester issues one command per cycle
	a_one_cmd: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_uart_wstart_rq && i_uart_rstart_rq) && !(i_dc_wstart_rq && i_dc_rstart_rq));

	// a held slot must drain before its source strobes again
	a_pend_room: assert property (@(posedge i_clk) disable iff (i_reset)
		(new_vld & pend_vld & ~take_pend) == 2'b00);

endmodule

//--- src/line_req_fifo.sv
// line request queue
`timescale 1ns/1ns
`include "mem_macros.svh"

module line_req_fifo
	import bus_types_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input logic i_push,
	input line_req_t i_req,
	input logic i_pop,
	output line_req_t o_head,
	output logic o_not_empty,
	output logic o_rqfull
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = $clog2(`FIFO_DEPTH + 1);

	line_req_t mem [`FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(`FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	always_comb begin
		count_next = count;
		if (i_push && !i_pop)
			count_next = count + 1'b1;
		else if (!i_push && i_pop)
			count_next = count - 1'b1;
	end

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			o_rqfull <= 1'b0;
		end else begin
			if (i_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (i_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count_next;
			o_rqfull <= count_next >= CNT_W'(`FIFO_DEPTH - `FIFO_AFULL_MARGIN); // early warning
		end
	end

	always_ff @(posedge i_clk) begin
		if (i_push)
			mem[wr_ptr] <= i_req;
	end

	assign o_head = mem[rd_ptr];
	assign o_not_empty = (count != '0);

	// requesters ignored rqfull
	a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_push && count == CNT_W'(`FIFO_DEPTH)));

	a_no_underflow: assert property (@(posedge i_clk) disable iff (i_reset)
		!(i_pop && count == '0));

endmodule

//--- src/dram_line_ctrl.sv
// dram line controller model
`timescale 1ns/1ns
`include "mem_macros.svh"

module dram_line_ctrl
	import bus_types_pkg::*;
	import dram_types_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input line_req_t i_head,
	input logic i_not_empty,
	output logic o_pop,
	output line_rsp_t o_uart_rsp,
	output line_rsp_t o_dc_rsp
);

	localparam int CNT_W = $clog2(`DRAM_RD_CYCLES > `DRAM_WR_CYCLES ?
		`DRAM_RD_CYCLES : `DRAM_WR_CYCLES);

	ctrl_state_e state;
	logic [CNT_W-1:0] lat_cnt;
	line_req_t cur; // request being served
	line_idx_t cur_idx;
	line_data_t store [`LINE_ENTRIES];
	logic [`LINE_ENTRIES-1:0] written; // unwritten lines read as zero
	line_data_t rd_line;
	line_data_t rd_data;

	// mask bit 1 keeps the old byte
	function automatic line_data_t merge_line(
		input line_data_t old_line,
		input line_data_t new_line,
		input byte_mask_t mask
	);
		line_data_t res;
		for (int b = 0; b < $bits(byte_mask_t); b++) begin
			res[b*8 +: 8] = mask[b] ? old_line[b*8 +: 8] : new_line[b*8 +: 8];
		end
		return res;
	endfunction

	function automatic line_rsp_t make_rsp(
		input req_src_e src,
		input logic in_resp,
		input line_req_t req,
		input line_data_t data
	);
		line_rsp_t rsp;
		rsp = '0;
		if (in_resp && req.src == src) begin
			rsp.finish_wresp = (req.cmd == CMD_WRITE);
			rsp.rdat_valid = (req.cmd == CMD_READ);
			rsp.rdat = (req.cmd == CMD_READ) ? data : '0;
		end
		return rsp;
	endfunction

	assign o_pop = (state == CTRL_IDLE) && i_not_empty;
	assign cur_idx = cur.addr[7:4];
	assign rd_line = written[cur_idx] ? store[cur_idx] : '0;

	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			state <= CTRL_IDLE;
			lat_cnt <= '0;
			written <= '0;
		end else begin
			case (state)
			CTRL_IDLE: begin
				if (o_pop) begin
					state <= (i_head.cmd == CMD_WRITE) ? CTRL_WRITE : CTRL_READ;
					lat_cnt <= (i_head.cmd == CMD_WRITE) ? CNT_W'(`DRAM_WR_CYCLES - 2) :
						CNT_W'(`DRAM_RD_CYCLES - 2);
				end
			end
			CTRL_WRITE: begin
				if (lat_cnt == '0) begin
					state <= CTRL_RESP;
					written[cur_idx] <= 1'b1;
				end else begin
					lat_cnt <= lat_cnt - 1'b1;
				end
			end
			CTRL_READ: begin
				if (lat_cnt == '0)
					state <= CTRL_RESP;
				else
					lat_cnt <= lat_cnt - 1'b1;
			end
			CTRL_RESP: state <= CTRL_IDLE; // pop allowed next cycle
			default: state <= CTRL_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_pop)
			cur <= i_head;
		if (state == CTRL_WRITE && lat_cnt == '0)
			store[cur_idx] <= merge_line(rd_line, cur.data, cur.mask);
		if (state == CTRL_READ && lat_cnt == '0)
			rd_data <= rd_line;
	end

	always_comb begin
		o_uart_rsp = make_rsp(SRC_UART, state == CTRL_RESP, cur, rd_data);
		o_dc_rsp = make_rsp(SRC_DC, state == CTRL_RESP, cur, rd_data);
	end

	// one strobe to one source per response cycle
	a_one_rsp: assert property (@(posedge i_clk) disable iff (i_reset)
		state == CTRL_RESP |-> $onehot({o_uart_rsp.finish_wresp, o_uart_rsp.rdat_valid,
			o_dc_rsp.finish_wresp, o_dc_rsp.rdat_valid}));

	// read data arrives exactly DRAM_RD_CYCLES after the pop
	a_rd_latency: assert property (@(posedge i_clk) disable iff (i_reset)
		o_pop && i_head.cmd == CMD_READ |-> ##(`DRAM_RD_CYCLES)
			(o_uart_rsp.rdat_valid || o_dc_rsp.rdat_valid));

endmodule

//--- src/mem_subsys_top.sv
// memory subsystem top
`timescale 1ns/1ns

module mem_subsys_top
	import bus_types_pkg::*;
	import dram_types_pkg::*;
(
	input logic i_clk,
	input logic i_reset,
	input logic i_uart_wstart_rq,
	input bus_addr_t i_uart_win_addr,
	input line_data_t i_uart_in_wdata,
	input byte_mask_t i_uart_in_mask,
	input logic i_uart_rstart_rq,
	input bus_addr_t i_uart_rin_addr,
	output logic o_uart_finish_wresp,
	output logic o_uart_rdat_m_valid,
	output line_data_t o_uart_rdat_m_data,
	output logic o_uart_finish_mrd,
	input logic i_dc_wstart_rq,
	input bus_addr_t i_dc_win_addr,
	input line_data_t i_dc_in_wdata,
	input byte_mask_t i_dc_in_mask,
	input logic i_dc_rstart_rq,
	input bus_addr_t i_dc_rin_addr,
	output logic o_dc_finish_wresp,
	output logic o_dc_rdat_m_valid,
	output line_data_t o_dc_rdat_m_data,
	output logic o_dc_finish_mrd,
	output logic o_rqfull
);

	logic push;
	line_req_t req; // arbiter to queue
	logic pop;
	line_req_t head; // queue to controller
	logic not_empty;
	line_rsp_t uart_rsp;
	line_rsp_t dc_rsp;

	bus_req_arbiter bus_req_arbiter_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_uart_wstart_rq(i_uart_wstart_rq),
		.i_uart_win_addr(i_uart_win_addr),
		.i_uart_in_wdata(i_uart_in_wdata),
		.i_uart_in_mask(i_uart_in_mask),
		.i_uart_rstart_rq(i_uart_rstart_rq),
		.i_uart_rin_addr(i_uart_rin_addr),
		.i_dc_wstart_rq(i_dc_wstart_rq),
		.i_dc_win_addr(i_dc_win_addr),
		.i_dc_in_wdata(i_dc_in_wdata),
		.i_dc_in_mask(i_dc_in_mask),
		.i_dc_rstart_rq(i_dc_rstart_rq),
		.i_dc_rin_addr(i_dc_rin_addr),
		.o_push(push),
		.o_req(req)
	);

	line_req_fifo line_req_fifo_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_push(push),
		.i_req(req),
		.i_pop(pop),
		.o_head(head),
		.o_not_empty(not_empty),
		.o_rqfull(o_rqfull)
	);

	dram_line_ctrl dram_line_ctrl_i (
		.i_clk(i_clk),
		.i_reset(i_reset),
		.i_head(head),
		.i_not_empty(not_empty),
		.o_pop(pop),
		.o_uart_rsp(uart_rsp),
		.o_dc_rsp(dc_rsp)
	);

	assign o_uart_finish_wresp = uart_rsp.finish_wresp;
	assign o_uart_rdat_m_valid = uart_rsp.rdat_valid;
	assign o_uart_rdat_m_data = uart_rsp.rdat;
	assign o_uart_finish_mrd = uart_rsp.rdat_valid; // read finishes with its data
	assign o_dc_finish_wresp = dc_rsp.finish_wresp;
	assign o_dc_rdat_m_valid = dc_rsp.rdat_valid;
	assign o_dc_rdat_m_data = dc_rsp.rdat;
	assign o_dc_finish_mrd = dc_rsp.rdat_valid;

endmodule

//--- verif/mem_subsys_tb.sv
// memory subsystem testbench
`timescale 1ns/1ns
`include "mem_macros.svh"

module mem_subsys_tb
	import bus_types_pkg::*;
	import dram_types_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 200;

	typedef struct packed {
		logic is_read;
		line_data_t data;
	} exp_rsp_t;

	logic i_clk;
	logic i_reset;
	logic uart_wstart, uart_rstart, dc_wstart, dc_rstart;
	bus_addr_t uart_waddr, uart_raddr, dc_waddr, dc_raddr;
	line_data_t uart_wdata, dc_wdata;
	byte_mask_t uart_mask, dc_mask;
	logic uart_wfin, uart_rvld, uart_rfin, dc_wfin, dc_rvld, dc_rfin;
	line_data_t uart_rdata, dc_rdata;
	logic rqfull;

	line_data_t model_store [`LINE_ENTRIES];
	exp_rsp_t uart_exp [$];
	exp_rsp_t dc_exp [$];
	logic [31:0] lcg_state;
	string test_name;
	int full_waits; // cycles spent held off by rqfull

	mem_subsys_top mem_subsys_top_i (
		.i_clk(i_clk), .i_reset(i_reset),
		.i_uart_wstart_rq(uart_wstart), .i_uart_win_addr(uart_waddr),
		.i_uart_in_wdata(uart_wdata), .i_uart_in_mask(uart_mask),
		.i_uart_rstart_rq(uart_rstart), .i_uart_rin_addr(uart_raddr),
		.o_uart_finish_wresp(uart_wfin), .o_uart_rdat_m_valid(uart_rvld),
		.o_uart_rdat_m_data(uart_rdata), .o_uart_finish_mrd(uart_rfin),
		.i_dc_wstart_rq(dc_wstart), .i_dc_win_addr(dc_waddr),
		.i_dc_in_wdata(dc_wdata), .i_dc_in_mask(dc_mask),
		.i_dc_rstart_rq(dc_rstart), .i_dc_rin_addr(dc_raddr),
		.o_dc_finish_wresp(dc_wfin), .o_dc_rdat_m_valid(dc_rvld),
		.o_dc_rdat_m_data(dc_rdata), .o_dc_finish_mrd(dc_rfin),
		.o_rqfull(rqfull)
	);

	always #20 i_clk = ~i_clk;

	// mask bit 1 keeps the old byte
	function automatic line_data_t merge_ref(input line_data_t old_line,
		input line_data_t new_line, input byte_mask_t mask);
		line_data_t res;
		for (int b = 0; b < 16; b++)
			res[b*8 +: 8] = mask[b] ? old_line[b*8 +: 8] : new_line[b*8 +: 8];
		return res;
	endfunction

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic line_data_t rand_line();
		return {next_rand(), next_rand(), next_rand(), next_rand()};
	endfunction

	task automatic fail_msg(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	task automatic fail_value(input string what, input logic [127:0] exp, input logic [127:0] act);
		$display("ERROR %s: expected %h actual %h", what, exp, act);
		$display("Simulation FAILED");
		$fatal(1);
	endtask

	// called right after a rising edge and updates the model in issue order
	task automatic set_req(input req_src_e src, input req_cmd_e cmd, input bus_addr_t addr,
		input line_data_t data, input byte_mask_t mask);
		exp_rsp_t exp;
		line_idx_t idx;
		idx = addr[7:4];
		exp.is_read = (cmd == CMD_READ);
		exp.data = '0;
		if (cmd == CMD_WRITE)
			model_store[idx] = merge_ref(model_store[idx], data, mask);
		else
			exp.data = model_store[idx];
		if (src == SRC_DC) begin
			dc_wstart <= (cmd == CMD_WRITE);
			dc_rstart <= (cmd == CMD_READ);
			dc_waddr <= addr;
			dc_raddr <= addr;
			dc_wdata <= data;
			dc_mask <= mask;
			dc_exp.push_back(exp);
		end else begin
			uart_wstart <= (cmd == CMD_WRITE);
			uart_rstart <= (cmd == CMD_READ);
			uart_waddr <= addr;
			uart_raddr <= addr;
			uart_wdata <= data;
			uart_mask <= mask;
			uart_exp.push_back(exp);
		end
	endtask

	task automatic clear_strobes();
		uart_wstart <= 1'b0;
		uart_rstart <= 1'b0;
		dc_wstart <= 1'b0;
		dc_rstart <= 1'b0;
	endtask

	task automatic wait_room();
		int n;
		n = 0;
		@(negedge i_clk);
		while (rqfull) begin
			n++;
			full_waits++;
			if (n > TIMEOUT_CYCLES)
				fail_msg($sformatf("%s: rqfull never fell", test_name));
			@(negedge i_clk);
		end
	endtask

	task automatic send(input req_src_e src, input req_cmd_e cmd, input bus_addr_t addr,
		input line_data_t data, input byte_mask_t mask);
		wait_room();
		@(posedge i_clk);
		set_req(src, cmd, addr, data, mask);
		@(posedge i_clk);
		clear_strobes();
	endtask

	task automatic wait_queue_empty(input req_src_e src);
		int n;
		n = 0;
		while ((src == SRC_DC) ? dc_exp.size() != 0 : uart_exp.size() != 0) begin
			n++;
			if (n > TIMEOUT_CYCLES)
				fail_msg($sformatf("%s: a %s response never arrived", test_name,
					(src == SRC_DC) ? "dc" : "uart"));
			@(posedge i_clk);
		end
	endtask

	task automatic check_rsp(input req_src_e src, input logic wr_fin, input logic rd_vld,
		input logic rd_fin, input line_data_t rd_data);
		exp_rsp_t exp;
		string who;
		if (!(wr_fin || rd_vld || rd_fin))
			return;
		who = (src == SRC_DC) ? "dc" : "uart";
		if (src == SRC_DC) begin
			assert (dc_exp.size() > 0)
				else fail_msg($sformatf("%s: unexpected dc response", test_name));
			exp = dc_exp.pop_front();
		end else begin
			assert (uart_exp.size() > 0)
				else fail_msg($sformatf("%s: unexpected uart response", test_name));
			exp = uart_exp.pop_front();
		end
		assert ({wr_fin, rd_vld, rd_fin} == (exp.is_read ? 3'b011 : 3'b100))
			else fail_value({test_name, " ", who, " strobes"}, exp.is_read ? 3'b011 : 3'b100,
				{wr_fin, rd_vld, rd_fin});
		if (exp.is_read) begin
			assert (rd_data == exp.data)
				else fail_value({test_name, " ", who, " read data"}, exp.data, rd_data);
		end
	endtask

	// outputs settle after the rising edge
	always @(negedge i_clk) begin
		if (!i_reset) begin
			check_rsp(SRC_UART, uart_wfin, uart_rvld, uart_rfin, uart_rdata);
			check_rsp(SRC_DC, dc_wfin, dc_rvld, dc_rfin, dc_rdata);
		end
	end

	initial begin
		line_data_t a;
		req_src_e src;
		logic [31:0] r;
		i_clk = 1'b0;
		i_reset = 1'b1;
		uart_wstart = 1'b0;
		uart_rstart = 1'b0;
		dc_wstart = 1'b0;
		dc_rstart = 1'b0;
		uart_waddr = '0;
		uart_raddr = '0;
		dc_waddr = '0;
		dc_raddr = '0;
		uart_wdata = '0;
		dc_wdata = '0;
		uart_mask = '0;
		dc_mask = '0;
		lcg_state = 32'd86;
		full_waits = 0;
		test_name = "reset_quiet";
		for (int i = 0; i < `LINE_ENTRIES; i++)
			model_store[i] = '0;
		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;

		for (int i = 0; i < 4; i++) begin
			@(negedge i_clk);
			assert (!{uart_wfin, uart_rvld, uart_rfin, dc_wfin, dc_rvld, dc_rfin, rqfull})
				else fail_msg("reset_quiet: a strobe or rqfull is high after reset");
		end
		send(SRC_UART, CMD_READ, 32'h0000_0050, '0, '0); // never written
		wait_queue_empty(SRC_UART);

		test_name = "write_read";
		send(SRC_DC, CMD_WRITE, 32'h0000_0020, rand_line(), 16'h0000);
		send(SRC_DC, CMD_READ, 32'h0000_0020, '0, '0);
		wait_queue_empty(SRC_DC);

		test_name = "masked_merge";
		a = rand_line();
		send(SRC_UART, CMD_WRITE, 32'h0000_0070, a, 16'h0000);
		send(SRC_UART, CMD_WRITE, 32'h0000_0074, ~a, 16'hA5C3);
		send(SRC_UART, CMD_READ, 32'h0000_0078, '0, '0);
		wait_queue_empty(SRC_UART);

		test_name = "collision_routing";
		wait_room();
		@(posedge i_clk);
		set_req(SRC_DC, CMD_WRITE, 32'h0000_0090, rand_line(), 16'h0000); // dc wins
		set_req(SRC_UART, CMD_WRITE, 32'h0000_00A0, rand_line(), 16'h00FF);
		@(posedge i_clk);
		clear_strobes();
		wait_queue_empty(SRC_DC);
		assert (uart_exp.size() == 1)
			else fail_value("collision_routing uart pending", 1, uart_exp.size());
		wait_room();
		@(posedge i_clk);
		set_req(SRC_DC, CMD_READ, 32'h0000_0090, '0, '0);
		set_req(SRC_UART, CMD_READ, 32'h0000_00A0, '0, '0);
		@(posedge i_clk);
		clear_strobes();
		wait_queue_empty(SRC_DC);
		wait_queue_empty(SRC_UART);

		test_name = "random_stream";
		full_waits = 0;
		for (int i = 0; i < 200; i++) begin
			r = next_rand();
			src = r[8] ? SRC_DC : SRC_UART;
			send(src, r[9] ? CMD_READ : CMD_WRITE, next_rand(), rand_line(), r[31:16]);
		end
		wait_queue_empty(SRC_DC);
		wait_queue_empty(SRC_UART);
		assert (full_waits > 0)
			else fail_msg("random_stream: rqfull never rose while requests were queued");

		if (uart_exp.size() == 0 && dc_exp.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			fail_msg("responses left outstanding at the end of the run");
		end
	end

endmodule

//--- mem_subsys.f
+incdir+src
src/dram_types_pkg.sv
src/bus_types_pkg.sv
src/bus_req_arbiter.sv
src/line_req_fifo.sv
src/dram_line_ctrl.sv
src/mem_subsys_top.sv
verif/mem_subsys_tb.sv
